//--- bench/sd_cmd_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_assertions (
  input logic         clk_i,
  input logic         rst_ni,
  input logic         clk_en_p_i,  // cycle before sd_clk rises
  input logic         cmd_start_i,
  input logic [5:0]   cmd_index_i,
  input logic [31:0]  cmd_arg_i,
  input logic [1:0]   rsp_type_i,
  input logic         sd_cmd_o,
  input logic         sd_cmd_oe_o,
  input logic         sd_cmd_i,
  input logic         dat0_i,
  input logic         listening_i,
  input logic         ready_i,
  input logic         cmd_inhibit_o,
  input logic         cmd_done_o,
  input logic         rsp_done_o,
  input logic [119:0] rsp_o,
  input logic         busy_o,
  input logic         timeout_err_o,
  input logic         crc_err_o,
  input logic         end_bit_err_o,
  input logic         index_err_o
);

  int unsigned  err_cnt = 0;
  logic         accept, oe_q, tx_pend;
  logic [47:0]  tx_sr, exp_frame;
  logic [6:0]   tx_cnt;
  logic [5:0]   idx_q;
  logic [31:0]  arg_q;
  logic [1:0]   type_q;
  logic [135:0] rx_sr;
  logic [7:0]   rx_cnt, rx_len;
  logic         rx_on, rx_got;
  logic         done_pend; // accepted command still owes its rsp_done_o
  logic [3:0]   flags_q, exp_flags; // timeout, crc, end bit, index

  // reference crc7 over the low n bits of d, msb first
  function automatic logic [6:0] crc7_ref(logic [119:0] d, int n);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = n - 1; i >= 0; i--) begin
      fb = c[6] ^ d[i];
      c  = {c[5:0], 1'b0};
      if (fb) c = c ^ 7'h09; // x^7 + x^3 + 1
    end
    return c;
  endfunction

  assign accept    = cmd_start_i && !cmd_inhibit_o;
  assign rx_len    = (type_q == sd_proto_pkg::RSP_LONG) ? 8'd136 : 8'd48;
  assign exp_frame = {2'b01, idx_q, arg_q, crc7_ref({2'b01, idx_q, arg_q}, 40), 1'b1};

  always_comb begin
    exp_flags = '0;
    if (type_q != sd_proto_pkg::RSP_NONE) begin
      if (!rx_got) begin
        exp_flags[3] = 1'b1;
      end else begin
        exp_flags[1] = !rx_sr[0];
        if (type_q != sd_proto_pkg::RSP_LONG) begin
          exp_flags[2] = (crc7_ref(rx_sr[47:8], 40) != rx_sr[7:1]);
          exp_flags[0] = (rx_sr[45:40] != idx_q);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // rebuild host frame and card response
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      oe_q      <= 1'b0;
      tx_pend   <= 1'b0;
      tx_cnt    <= '0;
      type_q    <= sd_proto_pkg::RSP_NONE;
      rx_on     <= 1'b0;
      rx_got    <= 1'b0;
      rx_cnt    <= '0;
      done_pend <= 1'b0;
      flags_q   <= '0;
    end else begin
      oe_q <= sd_cmd_oe_o;
      if (accept) begin
        idx_q     <= cmd_index_i;
        arg_q     <= cmd_arg_i;
        type_q    <= rsp_type_i;
        tx_pend   <= 1'b1;
        rx_on     <= 1'b0;
        rx_got    <= 1'b0;
        rx_cnt    <= '0;
        done_pend <= 1'b1;
      end
      if (sd_cmd_oe_o && !oe_q) tx_pend <= 1'b0; // frame consumed its start
      if (!sd_cmd_oe_o) begin
        tx_cnt <= '0;
      end else if (clk_en_p_i) begin
        tx_sr  <= {tx_sr[46:0], sd_cmd_o};
        tx_cnt <= tx_cnt + 1'b1;
      end
      if (clk_en_p_i && !sd_cmd_oe_o && (type_q != sd_proto_pkg::RSP_NONE)) begin
        if (rx_on) begin
          rx_sr  <= {rx_sr[134:0], sd_cmd_i};
          rx_cnt <= rx_cnt + 1'b1;
          if (rx_cnt == rx_len - 1) rx_on <= 1'b0;
        end else if (!rx_got && !sd_cmd_i) begin
          rx_on  <= 1'b1; // start bit
          rx_got <= 1'b1;
          rx_sr  <= '0;
          rx_cnt <= 8'd1;
        end
      end
      if (rsp_done_o) begin
        flags_q   <= {timeout_err_o, crc_err_o, end_bit_err_o, index_err_o};
        done_pend <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_frame: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(sd_cmd_oe_o) |-> (tx_cnt == 7'd48) && (tx_sr == exp_frame))
    else begin
      err_cnt++;
      $error("error at %0t: sd_cmd_o frame got %h (%0d bits) expected %h", $time,
             $sampled(tx_sr), $sampled(tx_cnt), $sampled(exp_frame));
    end

  a_no_extra_frame: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(sd_cmd_oe_o) |-> tx_pend)
    else begin
      err_cnt++;
      $error("a frame went out without an accepted start");
    end

  // the end bit is sampled by the card on the same sd_clk edge
  a_cmd_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_done_o == (clk_en_p_i && sd_cmd_oe_o && (tx_cnt == 7'd47)))
    else begin
      err_cnt++;
      $error("cmd_done_o is out of step with the end bit of the frame");
    end

  a_flags: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_done_o |=> (flags_q == exp_flags))
    else begin
      err_cnt++;
      $error("error at %0t: error flags got %b expected %b", $time,
             $sampled(flags_q), $sampled(exp_flags));
    end

  a_done_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_done_o |-> done_pend)
    else begin
      err_cnt++;
      $error("rsp_done_o pulsed without a command waiting for it");
    end

  a_short_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_done_o && rx_got && ((type_q == sd_proto_pkg::RSP_SHORT) ||
                             (type_q == sd_proto_pkg::RSP_SHORT_BUSY))
    |=> (rsp_o[31:0] == rx_sr[39:8]))
    else begin
      err_cnt++;
      $error("error at %0t: rsp_o[31:0] got %h expected %h", $time,
             $sampled(rsp_o[31:0]), $sampled(rx_sr[39:8]));
    end

  a_long_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_done_o && rx_got && (type_q == sd_proto_pkg::RSP_LONG) |=> (rsp_o == rx_sr[127:8]))
    else begin
      err_cnt++;
      $error("error at %0t: rsp_o got %h expected %h", $time,
             $sampled(rsp_o), $sampled(rx_sr[127:8]));
    end

  a_inhibit_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> cmd_inhibit_o)
    else begin
      err_cnt++;
      $error("cmd_inhibit_o did not rise after an accepted start");
    end

  a_inhibit_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !cmd_inhibit_o |-> ready_i)
    else begin
      err_cnt++;
      $error("cmd_inhibit_o is low while the sequencer is not ready");
    end

  a_busy_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && (rsp_type_i == sd_proto_pkg::RSP_SHORT_BUSY) |=> busy_o)
    else begin
      err_cnt++;
      $error("busy_o did not rise for a busy command");
    end

  a_busy_type: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_o |-> (type_q == sd_proto_pkg::RSP_SHORT_BUSY))
    else begin
      err_cnt++;
      $error("busy_o is high for a command without busy");
    end

  a_busy_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(busy_o) |-> (dat0_i && (rx_cnt == rx_len)) || !rx_got)
    else begin
      err_cnt++;
      $error("busy_o fell before the response and the dat0 release");
    end

  a_no_listen: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (type_q == sd_proto_pkg::RSP_NONE) |-> !listening_i)
    else begin
      err_cnt++;
      $error("the reader listened for a command without response");
    end

endmodule

bind sd_cmd_top sd_cmd_assertions u_chk (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .clk_en_p_i    (clk_en_p),
  .cmd_start_i   (cmd_start_i),
  .cmd_index_i   (cmd_index_i),
  .cmd_arg_i     (cmd_arg_i),
  .rsp_type_i    (rsp_type_i),
  .sd_cmd_o      (sd_cmd_o),
  .sd_cmd_oe_o   (sd_cmd_oe_o),
  .sd_cmd_i      (sd_cmd_i),
  .dat0_i        (dat0_i),
  .listening_i   (start_listening),
  .ready_i       (i_cmd_ctrl.state_q == sd_host_pkg::READY),
  .cmd_inhibit_o (cmd_inhibit_o),
  .cmd_done_o    (cmd_done_o),
  .rsp_done_o    (rsp_done_o),
  .rsp_o         (rsp_o),
  .busy_o        (busy_o),
  .timeout_err_o (timeout_err_o),
  .crc_err_o     (crc_err_o),
  .end_bit_err_o (end_bit_err_o),
  .index_err_o   (index_err_o)
);

`default_nettype wire

//--- bench/sd_cmd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_tb;

  logic         clk_i = 1'b0;
  logic         rst_ni = 1'b0;
  logic         cmd_start_i = 1'b0;
  logic [5:0]   cmd_index_i = '0;
  logic [31:0]  cmd_arg_i = '0;
  logic [1:0]   rsp_type_i = '0;
  logic         sd_cmd_i = 1'b1; // card side, idle high
  logic         dat0_i = 1'b1;
  logic         sd_clk_o, sd_cmd_o, sd_cmd_oe_o, cmd_inhibit_o, cmd_done_o, rsp_done_o;
  logic [119:0] rsp_o;
  logic         busy_o, timeout_err_o, crc_err_o, end_bit_err_o, index_err_o;
  int           seed = 32'h1534_8665;

  // card answer modes
  localparam int ANS_OK = 0, ANS_BAD_CRC = 1, ANS_BAD_IDX = 2, ANS_BAD_END = 3, ANS_NONE = 4;

  always #4 clk_i = ~clk_i; // 8 ns period

  sd_cmd_top sd_cmd_top_inst (.*);

  // any failed assertion ends the run
  always @(posedge clk_i) begin
    if (sd_cmd_top_inst.u_chk.err_cnt != 0) begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "assertion check failed");
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "%s", why);
  endtask

  function automatic logic [6:0] crc7_serial(logic [119:0] d, int n);
    logic [6:0] c;
    c = '0;
    for (int i = n - 1; i >= 0; i--) begin
      c = {c[5:0], 1'b0} ^ ((c[6] ^ d[i]) ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  task automatic wait_idle();
    int n;
    n = 0;
    while (cmd_inhibit_o) begin
      @(negedge clk_i);
      n++;
      if (n > 4000) abort_run("timeout waiting for cmd_inhibit_o to fall");
    end
  endtask

  task automatic wait_rsp_done();
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > 4000) abort_run("timeout waiting for rsp_done_o");
    end while (!rsp_done_o);
  endtask

  // card side, sampling the host frame on rising sd_clk
  task automatic take_frame();
    int n;
    n = 0;
    do begin
      @(posedge sd_clk_o);
      n++;
      if (n > 10) abort_run("no command frame started on sd_cmd_o");
    end while (!(sd_cmd_oe_o && !sd_cmd_o));
    repeat (47) @(posedge sd_clk_o);
  endtask

  task automatic card_answer(input logic [5:0] idx, input logic [1:0] typ, input int mode);
    logic [135:0] f;
    logic [119:0] body;
    int           len, gap;
    body = {$random(seed), $random(seed), $random(seed), $random(seed)};
    gap  = 1 + ($unsigned($random(seed)) % 9); // start bit after 2 to 10 sd clocks
    if (typ == sd_proto_pkg::RSP_LONG) begin
      len = 136;
      f   = {2'b00, 6'h3f, body, crc7_serial(body, 120), (mode != ANS_BAD_END)};
    end else begin
      len      = 48;
      f        = '0;
      f[47:8]  = {2'b00, (mode == ANS_BAD_IDX) ? idx ^ 6'h01 : idx, body[31:0]};
      f[7:1]   = crc7_serial(f[47:8], 40) ^ ((mode == ANS_BAD_CRC) ? 7'h01 : 7'h00);
      f[0]     = (mode != ANS_BAD_END);
    end
    repeat (gap) @(posedge sd_clk_o);
    for (int i = len - 1; i >= 0; i--) begin
      @(negedge sd_clk_o);
      @(negedge clk_i);
      sd_cmd_i = f[i];
    end
    @(negedge sd_clk_o);
    @(negedge clk_i);
    sd_cmd_i = 1'b1;
    if (typ == sd_proto_pkg::RSP_SHORT_BUSY) begin
      dat0_i = 1'b0; // card busy
      repeat (4 + ($unsigned($random(seed)) % 16)) @(negedge sd_clk_o);
      @(negedge clk_i);
      dat0_i = 1'b1;
    end
  endtask

  task automatic run_cmd(input logic [5:0] idx, input logic [1:0] typ, input int mode,
                         input bit restart);
    wait_idle();
    @(negedge clk_i);
    cmd_start_i = 1'b1;
    cmd_index_i = idx;
    cmd_arg_i   = $random(seed);
    rsp_type_i  = typ;
    @(negedge clk_i);
    cmd_start_i = 1'b0;
    if (restart) begin
      cmd_start_i = 1'b1; // must be dropped, inhibit is high
      cmd_index_i = ~idx;
      @(negedge clk_i);
      cmd_start_i = 1'b0;
    end
    fork
      begin
        take_frame();
        if ((typ != sd_proto_pkg::RSP_NONE) && (mode != ANS_NONE)) card_answer(idx, typ, mode);
      end
      wait_rsp_done();
    join
  endtask

  initial begin
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    run_cmd(6'd13, sd_proto_pkg::RSP_SHORT, ANS_OK, 1'b0);
    run_cmd(6'd17, sd_proto_pkg::RSP_SHORT, ANS_OK, 1'b1);
    run_cmd(6'd2, sd_proto_pkg::RSP_LONG, ANS_OK, 1'b0);
    run_cmd(6'd55, sd_proto_pkg::RSP_SHORT, ANS_BAD_CRC, 1'b0);
    run_cmd(6'd16, sd_proto_pkg::RSP_SHORT, ANS_BAD_IDX, 1'b0);
    run_cmd(6'd7, sd_proto_pkg::RSP_SHORT, ANS_BAD_END, 1'b0);
    run_cmd(6'd8, sd_proto_pkg::RSP_SHORT, ANS_NONE, 1'b0);
    run_cmd(6'd12, sd_proto_pkg::RSP_SHORT_BUSY, ANS_OK, 1'b0);
    run_cmd(6'd0, sd_proto_pkg::RSP_NONE, ANS_OK, 1'b0);
    run_cmd(6'd9, sd_proto_pkg::RSP_LONG, ANS_BAD_END, 1'b0);
    for (int k = 0; k < 4; k++) begin
      run_cmd(6'($random(seed)), sd_proto_pkg::RSP_SHORT_BUSY, ANS_OK, 1'b0);
    end
    wait_idle();
    repeat (20) @(negedge clk_i);
    if (sd_cmd_top_inst.u_chk.err_cnt == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "assertion check failed");
    end
  end

endmodule

`default_nettype wire

//--- sim.f
source/sd_proto_pkg.sv
source/sd_host_pkg.sv
source/sd_clk_gen.sv
source/cmd_write.sv
source/rsp_read.sv
source/cmd_ctrl.sv
source/sd_cmd_top.sv
bench/sd_cmd_assertions.sv
bench/sd_cmd_tb.sv

//--- source/cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_ctrl (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clk_en_p_i,
  input  logic         cmd_start_i,
  input  logic [5:0]   cmd_index_i,
  input  logic [31:0]  cmd_arg_i,
  input  logic [1:0]   rsp_type_i,
  input  logic         dat0_i,        // card busy while low
  input  logic         tx_done_i,
  input  logic         receiving_i,
  input  logic         rsp_valid_i,
  input  logic [119:0] rsp_i,
  input  logic         crc_ok_i,
  input  logic         end_bit_err_i,
  output logic         start_tx_o,
  output logic [5:0]   index_o,
  output logic [31:0]  arg_o,
  output logic         start_listening_o,
  output logic         long_rsp_o,
  output logic         cmd_inhibit_o,
  output logic         cmd_done_o,
  output logic         rsp_done_o,
  output logic [119:0] rsp_o,
  output logic         busy_o,
  output logic         timeout_err_o,
  output logic         crc_err_o,
  output logic         end_bit_err_o,
  output logic         index_err_o
);

  sd_host_pkg::cmd_seq_state_e state_q, state_d;

  logic [5:0]   cnt_q, cnt_d; // shared by N_CR, timeout and N_RC
  logic [5:0]   index_q;
  logic [31:0]  arg_q;
  logic [1:0]   rsp_type_q;
  logic [119:0] rsp_q;
  logic         inhibit_q, start_pend_q, busy_q;
  logic         rx_started_q, wait_busy_q;
  logic         crc_err_q, end_err_q, idx_err_q, to_err_q;
  logic         crc_err_d, end_err_d, idx_err_d, to_err_d;
  logic         accept, short_rsp, timeout, entering;

  assign accept    = cmd_start_i & ~inhibit_q; // starts during inhibit are dropped
  assign short_rsp = (rsp_type_q == sd_proto_pkg::RSP_SHORT) ||
                     (rsp_type_q == sd_proto_pkg::RSP_SHORT_BUSY);

  assign timeout = ((state_q == sd_host_pkg::READ_RSP) ||
                    (state_q == sd_host_pkg::READ_RSP_BUSY)) &&
                   !rx_started_q && !receiving_i &&
                   (cnt_q == 6'(sd_proto_pkg::RSP_TIMEOUT_CYCLES - 1));

  //////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      sd_host_pkg::READY: begin
        if (start_pend_q) state_d = sd_host_pkg::WRITE_CMD;
      end
      sd_host_pkg::WRITE_CMD: begin
        if (tx_done_i) begin
          state_d = (rsp_type_q == sd_proto_pkg::RSP_NONE) ? sd_host_pkg::RSP_RECEIVED
                                                           : sd_host_pkg::BUS_SWITCH;
        end
      end
      sd_host_pkg::BUS_SWITCH: begin
        if (cnt_q == 6'(sd_proto_pkg::NCR_GAP - 1)) begin
          state_d = (rsp_type_q == sd_proto_pkg::RSP_SHORT_BUSY) ? sd_host_pkg::READ_RSP_BUSY
                                                                 : sd_host_pkg::READ_RSP;
        end
      end
      sd_host_pkg::READ_RSP: begin
        if (rsp_valid_i || timeout) state_d = sd_host_pkg::RSP_RECEIVED;
      end
      sd_host_pkg::READ_RSP_BUSY: begin
        // response first, then hold until the card lets dat0 go
        if ((wait_busy_q && dat0_i) || timeout) state_d = sd_host_pkg::RSP_RECEIVED;
      end
      sd_host_pkg::RSP_RECEIVED: begin
        if (cnt_q == 6'(sd_proto_pkg::NRC_GAP - 1)) state_d = sd_host_pkg::READY;
      end
      default: state_d = sd_host_pkg::READY;
    endcase

    if (state_d != state_q) begin
      cnt_d = '0;
    end else if (rx_started_q || receiving_i) begin
      cnt_d = cnt_q; // response under way, no timeout
    end else if ((state_q != sd_host_pkg::READY) && (state_q != sd_host_pkg::WRITE_CMD)) begin
      cnt_d = cnt_q + 1'b1;
    end else begin
      cnt_d = cnt_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= sd_host_pkg::READY;
      cnt_q        <= '0;
      rx_started_q <= 1'b0;
      wait_busy_q  <= 1'b0;
    end else if (clk_en_p_i) begin
      state_q      <= state_d;
      cnt_q        <= cnt_d;
      rx_started_q <= (state_d != state_q) ? 1'b0 : (rx_started_q | receiving_i);
      wait_busy_q  <= (state_d != state_q) ? 1'b0 :
                      (wait_busy_q | (rsp_valid_i && (state_q == sd_host_pkg::READ_RSP_BUSY)));
    end
  end

  //////////////////////////////////////////////////
  // host side and error flags
  //////////////////////////////////////////////////

  assign entering = clk_en_p_i && (state_q != sd_host_pkg::RSP_RECEIVED) &&
                    (state_d == sd_host_pkg::RSP_RECEIVED);

  always_comb begin
    crc_err_d = crc_err_q;
    end_err_d = end_err_q;
    idx_err_d = idx_err_q;
    to_err_d  = to_err_q;
    if (accept) begin
      crc_err_d = 1'b0;
      end_err_d = 1'b0;
      idx_err_d = 1'b0;
      to_err_d  = 1'b0;
    end else begin
      if (rsp_valid_i) begin
        crc_err_d = short_rsp & ~crc_ok_i;
        end_err_d = end_bit_err_i;
        idx_err_d = short_rsp & (rsp_i[37:32] != index_q); // index field of R1/R1b
      end
      if (timeout && clk_en_p_i) to_err_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      inhibit_q    <= 1'b0;
      start_pend_q <= 1'b0;
      busy_q       <= 1'b0;
      rsp_type_q   <= sd_proto_pkg::RSP_NONE;
      crc_err_q    <= 1'b0;
      end_err_q    <= 1'b0;
      idx_err_q    <= 1'b0;
      to_err_q     <= 1'b0;
    end else begin
      crc_err_q <= crc_err_d;
      end_err_q <= end_err_d;
      idx_err_q <= idx_err_d;
      to_err_q  <= to_err_d;
      if (accept) begin
        inhibit_q    <= 1'b1;
        start_pend_q <= 1'b1;
        rsp_type_q   <= rsp_type_i;
        busy_q       <= (rsp_type_i == sd_proto_pkg::RSP_SHORT_BUSY);
      end else begin
        if (start_tx_o) start_pend_q <= 1'b0;
        if (entering) busy_q <= 1'b0;
        if (clk_en_p_i && (state_q == sd_host_pkg::RSP_RECEIVED) &&
            (state_d == sd_host_pkg::READY)) begin
          inhibit_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      index_q <= cmd_index_i;
      arg_q   <= cmd_arg_i;
    end
    if (rsp_valid_i) rsp_q <= rsp_i;
  end

  assign start_tx_o        = start_pend_q & clk_en_p_i & (state_q == sd_host_pkg::READY);
  assign index_o           = index_q;
  assign arg_o             = arg_q;
  assign start_listening_o = (state_q == sd_host_pkg::BUS_SWITCH);
  assign long_rsp_o        = (rsp_type_q == sd_proto_pkg::RSP_LONG);
  assign cmd_inhibit_o     = inhibit_q;
  assign cmd_done_o        = tx_done_i & (state_q == sd_host_pkg::WRITE_CMD);
  assign rsp_done_o        = entering;
  assign rsp_o             = rsp_q;
  assign busy_o            = busy_q;
  assign timeout_err_o     = entering & to_err_d;
  assign crc_err_o         = entering & crc_err_d;
  assign end_bit_err_o     = entering & end_err_d;
  assign index_err_o       = entering & idx_err_d;

endmodule

`default_nettype wire

//--- source/cmd_write.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_write (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clk_en_p_i,
  input  logic        clk_en_n_i,
  input  logic        start_tx_i,  // one cycle, index and argument valid
  input  logic [5:0]  cmd_index_i,
  input  logic [31:0] cmd_arg_i,
  output logic        cmd_o,
  output logic        cmd_oe_o,
  output logic        tx_done_o
);

  logic        sending_q;
  logic        end_sent_q; // end bit is on the line
  logic        cmd_q;
  logic        oe_q;
  logic [5:0]  bit_cnt_q;
  logic [39:0] frame_q;    // start, transmission, index, argument
  logic [6:0]  crc_q;

  //////////////////////////////////////////////////
  // bit sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sending_q  <= 1'b0;
      end_sent_q <= 1'b0;
      cmd_q      <= 1'b1; // line released high
      oe_q       <= 1'b0;
      bit_cnt_q  <= '0;
    end else begin
      if (clk_en_p_i) end_sent_q <= 1'b0;

      if (start_tx_i) begin
        sending_q <= 1'b1;
        bit_cnt_q <= '0;
      end else if (clk_en_n_i && sending_q) begin
        if (bit_cnt_q == 6'(sd_proto_pkg::CMD_FRAME_LEN)) begin
          // frame complete, hand the line back
          oe_q      <= 1'b0;
          cmd_q     <= 1'b1;
          sending_q <= 1'b0;
        end else begin
          oe_q      <= 1'b1;
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (bit_cnt_q < 6'(sd_proto_pkg::CMD_FRAME_LEN - 8)) begin
            cmd_q <= frame_q[39];
          end else if (bit_cnt_q < 6'(sd_proto_pkg::CMD_FRAME_LEN - 1)) begin
            cmd_q <= crc_q[6];
          end else begin
            cmd_q      <= 1'b1; // end bit
            end_sent_q <= 1'b1;
          end
        end
      end
    end
  end

  // shift register and crc, crc is built while the payload goes out
  always_ff @(posedge clk_i) begin
    if (start_tx_i) begin
      frame_q <= {2'b01, cmd_index_i, cmd_arg_i};
      crc_q   <= '0;
    end else if (clk_en_n_i && sending_q) begin
      if (bit_cnt_q < 6'(sd_proto_pkg::CMD_FRAME_LEN - 8)) begin
        frame_q <= {frame_q[38:0], 1'b0};
        crc_q   <= sd_proto_pkg::crc7_step(crc_q, frame_q[39]);
      end else begin
        crc_q <= {crc_q[5:0], 1'b0}; // shift crc out msb first
      end
    end
  end

  assign cmd_o     = cmd_q;
  assign cmd_oe_o  = oe_q;
  assign tx_done_o = end_sent_q & clk_en_p_i; // card has sampled the end bit

endmodule

`default_nettype wire

//--- source/rsp_read.sv
`timescale 1ns/1ps
`default_nettype none

module rsp_read (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clk_en_i,  // rising edge strobe
  input  logic         cmd_i,
  input  logic         long_rsp_i,
  input  logic         start_listening_i,
  output logic         receiving_o,
  output logic         rsp_valid_o,
  output logic [119:0] rsp_o,
  output logic         crc_ok_o,
  output logic         end_bit_err_o
);

  logic         armed_q;
  logic         recv_q;
  logic [7:0]   bit_cnt_q; // position in the frame, start bit is 0
  logic [7:0]   last_idx;
  logic         in_data;
  logic         in_crc;
  logic         crc_cover;
  logic         last_bit;
  logic [119:0] rsp_q;
  logic [6:0]   crc_calc_q;
  logic [6:0]   crc_rx_q;

  assign last_idx = long_rsp_i ? 8'(sd_proto_pkg::RSP_LONG_LEN - 1)
                               : 8'(sd_proto_pkg::RSP_SHORT_LEN - 1);

  // the seven bits before the end bit hold the crc
  assign last_bit = (bit_cnt_q == last_idx);
  assign in_data  = (bit_cnt_q < last_idx - 8'd7);
  assign in_crc   = !in_data && !last_bit;

  // long responses cover frame bits 127:8 only, which start at position 8
  assign crc_cover = in_data && (!long_rsp_i || (bit_cnt_q >= 8'd8));

  //////////////////////////////////////////////////
  // start bit detection and bit counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      armed_q   <= 1'b0;
      recv_q    <= 1'b0;
      bit_cnt_q <= '0;
    end else if (clk_en_i) begin
      if (recv_q) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        if (last_bit) recv_q <= 1'b0;
      end else if (armed_q && !cmd_i) begin
        armed_q   <= 1'b0; // start bit seen
        recv_q    <= 1'b1;
        bit_cnt_q <= 8'd1;
      end else if (start_listening_i) begin
        armed_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (clk_en_i) begin
      if (!recv_q) begin
        crc_calc_q <= '0;
      end else begin
        if (in_data) rsp_q <= {rsp_q[118:0], cmd_i}; // keeps the last 120 bits
        if (crc_cover) crc_calc_q <= sd_proto_pkg::crc7_step(crc_calc_q, cmd_i);
        if (in_crc) crc_rx_q <= {crc_rx_q[5:0], cmd_i};
      end
    end
  end

  assign receiving_o   = recv_q;
  assign rsp_valid_o   = recv_q & last_bit & clk_en_i;
  assign end_bit_err_o = recv_q & last_bit & ~cmd_i;
  assign crc_ok_o      = (crc_calc_q == crc_rx_q);
  assign rsp_o         = rsp_q;

endmodule

`default_nettype wire

//--- source/sd_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module sd_clk_gen (
  input  logic clk_i,
  input  logic rst_ni,
  output logic clk_en_p_o, // high in the cycle before sd_clk rises
  output logic clk_en_n_o, // high in the cycle before sd_clk falls
  output logic sd_clk_o
);

  logic [$clog2(sd_host_pkg::SD_CLK_DIV)-1:0] cnt_q, cnt_d;
  logic sd_clk_q;

  // modulo counter over one sd clock period
  assign cnt_d = (cnt_q == sd_host_pkg::SD_CLK_DIV - 1) ? '0 : cnt_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      sd_clk_q <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      // low in the first half of the count, high in the second
      sd_clk_q <= (cnt_d >= sd_host_pkg::SD_CLK_DIV / 2);
    end
  end

  // the strobes lead the pin by one clk_i cycle, so registers
  // enabled by them switch together with the sd clock edge
  assign clk_en_p_o = (cnt_q == sd_host_pkg::SD_CLK_DIV / 2 - 1);
  assign clk_en_n_o = (cnt_q == sd_host_pkg::SD_CLK_DIV - 1);

  assign sd_clk_o = sd_clk_q;

endmodule

`default_nettype wire

//--- source/sd_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_top (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         cmd_start_i,
  input  logic [5:0]   cmd_index_i,
  input  logic [31:0]  cmd_arg_i,
  input  logic [1:0]   rsp_type_i,
  input  logic         sd_cmd_i,
  input  logic         dat0_i,
  output logic         sd_clk_o,
  output logic         sd_cmd_o,
  output logic         sd_cmd_oe_o,
  output logic         cmd_inhibit_o,
  output logic         cmd_done_o,
  output logic         rsp_done_o,
  output logic [119:0] rsp_o,
  output logic         busy_o,
  output logic         timeout_err_o,
  output logic         crc_err_o,
  output logic         end_bit_err_o,
  output logic         index_err_o
);

  logic         clk_en_p, clk_en_n;
  logic         start_tx, tx_done;
  logic [5:0]   tx_index;
  logic [31:0]  tx_arg;
  logic         start_listening, long_rsp, receiving, rsp_valid;
  logic [119:0] rd_rsp;
  logic         rd_crc_ok, rd_end_bit_err;

  //////////////////////////////////////////////////
  // sd clock and command path
  //////////////////////////////////////////////////

  sd_clk_gen i_sd_clk_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clk_en_p_o (clk_en_p),
    .clk_en_n_o (clk_en_n),
    .sd_clk_o   (sd_clk_o)
  );

  cmd_ctrl i_cmd_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .clk_en_p_i        (clk_en_p),
    .cmd_start_i       (cmd_start_i),
    .cmd_index_i       (cmd_index_i),
    .cmd_arg_i         (cmd_arg_i),
    .rsp_type_i        (rsp_type_i),
    .dat0_i            (dat0_i),
    .tx_done_i         (tx_done),
    .receiving_i       (receiving),
    .rsp_valid_i       (rsp_valid),
    .rsp_i             (rd_rsp),
    .crc_ok_i          (rd_crc_ok),
    .end_bit_err_i     (rd_end_bit_err),
    .start_tx_o        (start_tx),
    .index_o           (tx_index),
    .arg_o             (tx_arg),
    .start_listening_o (start_listening),
    .long_rsp_o        (long_rsp),
    .cmd_inhibit_o     (cmd_inhibit_o),
    .cmd_done_o        (cmd_done_o),
    .rsp_done_o        (rsp_done_o),
    .rsp_o             (rsp_o),
    .busy_o            (busy_o),
    .timeout_err_o     (timeout_err_o),
    .crc_err_o         (crc_err_o),
    .end_bit_err_o     (end_bit_err_o),
    .index_err_o       (index_err_o)
  );

  cmd_write i_cmd_write (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clk_en_p_i  (clk_en_p),
    .clk_en_n_i  (clk_en_n),
    .start_tx_i  (start_tx),
    .cmd_index_i (tx_index),
    .cmd_arg_i   (tx_arg),
    .cmd_o       (sd_cmd_o),
    .cmd_oe_o    (sd_cmd_oe_o),
    .tx_done_o   (tx_done)
  );

  rsp_read i_rsp_read (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .clk_en_i          (clk_en_p), // sample on sd_clk rising
    .cmd_i             (sd_cmd_i),
    .long_rsp_i        (long_rsp),
    .start_listening_i (start_listening),
    .receiving_o       (receiving),
    .rsp_valid_o       (rsp_valid),
    .rsp_o             (rd_rsp),
    .crc_ok_o          (rd_crc_ok),
    .end_bit_err_o     (rd_end_bit_err)
  );

endmodule

`default_nettype wire

//--- source/sd_host_pkg.sv
`default_nettype none

package sd_host_pkg;

  // clk_i cycles per sd clock, must be even
  localparam int unsigned SD_CLK_DIV = 4;

  //////////////////////////////////////////////////
  // command sequencer states
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    READY,
    WRITE_CMD,
    BUS_SWITCH,    // N_CR gap before the response is expected
    READ_RSP,
    READ_RSP_BUSY, // response, then wait for dat0 release
    RSP_RECEIVED   // N_RC gap before the next command
  } cmd_seq_state_e;

endpackage

`default_nettype wire

//--- source/sd_proto_pkg.sv
`default_nettype none

package sd_proto_pkg;

  // response type select, as coded by the host
  localparam logic [1:0] RSP_NONE       = 2'b00;
  localparam logic [1:0] RSP_LONG       = 2'b01; // 136 bit
  localparam logic [1:0] RSP_SHORT      = 2'b10; // 48 bit
  localparam logic [1:0] RSP_SHORT_BUSY = 2'b11; // 48 bit, then busy on dat0

  localparam int unsigned CMD_FRAME_LEN = 48;
  localparam int unsigned RSP_SHORT_LEN = 48;
  localparam int unsigned RSP_LONG_LEN  = 136;

  // x^7 + x^3 + 1, the x^7 term is implied by the shift
  localparam logic [6:0] CRC7_POLY = 7'h09;

  localparam int unsigned RSP_TIMEOUT_CYCLES = 64; // sd clocks until start bit
  localparam int unsigned NCR_GAP = 2;             // sd clocks before listening
  localparam int unsigned NRC_GAP = 8;             // sd clocks before next command

  // one serial crc7 step, msb first
  function automatic logic [6:0] crc7_step(logic [6:0] crc, logic din);
    logic fb;
    fb = crc[6] ^ din;
    return {crc[5:0], 1'b0} ^ ({7{fb}} & CRC7_POLY);
  endfunction

endpackage

`default_nettype wire
